/* design/mbBufferPkg.sv */
// Buffer geometry constants, word index and mask types, MB status struct
package mbBufferPkg;

  //////////////////////
  // Buffer geometry
  //////////////////////

  // Four words, selected by address bits 34:35
  localparam int unsigned mbWords = 32'd4;

  // Word index, 0 is the word with address bits 34:35 both zero
  typedef logic [1:0] wordIdxT;

  // One bit per buffer word, bit i belongs to word i
  typedef logic [mbWords-1:0] wordMaskT;

  //////////////////////
  // Buffer status
  //////////////////////

  // Write request tracking state seen by the rest of the MB control
  typedef struct packed {
    // Words loaded into the buffer and not yet written out
    wordMaskT mbWrRq;
    // Word currently selected for the next move
    wordIdxT  mbSel;
    // Any write request pending
    logic     mbReqHold;
  } mbStatusT;

endpackage

/* design/mbCyclePkg.sv */
// Cache cycle type enum, cycle request and memory request structs, sequencer state enum
package mbCyclePkg;

  //////////////////////
  // Cache cycles
  //////////////////////

  // Cycle currently run by the cache control
  typedef enum logic [2:0] {
    cycIdle         = 3'd0,
    cycCoreRead     = 3'd1,
    cycOneWordRead  = 3'd2,
    cycOneWordWrite = 3'd3,
    cycWriteback    = 3'd4,
    cycPageRefill   = 3'd5
  } cycleTypeT;

  // Held by the cache control for the whole cycle
  typedef struct packed {
    cycleTypeT            cycType;
    // Addressed word of a one-word read
    mbBufferPkg::wordIdxT  wordAdr;
    // Words already valid in the cache line
    mbBufferPkg::wordMaskT cshWdVal;
  } cycleReqT;

  //////////////////////
  // Memory requests
  //////////////////////

  typedef struct packed {
    mbBufferPkg::wordMaskT rqIn;
    logic                  memRdRqIn;
    logic                  memWrRqIn;
  } memReqT;

  // Writeback phases, cache to MB
  typedef enum logic [2:0] {
    seqIdle  = 3'd0,
    seqOutEn = 3'd1,
    seqT1    = 3'd2,
    seqT2    = 3'd3,
    seqT3    = 3'd4,
    seqT4    = 3'd5
  } seqStateT;

endpackage

/* design/wordRequestTracker.sv */
// Per-word write request register, buffer word select and request hold flag
`timescale 1ns/100ps

module wordRequestTracker (
  input  logic                  clk,
  input  logic                  rstN,
  input  mbBufferPkg::wordMaskT wordsComing,
  input  logic                  mbWrRqClr,
  output mbBufferPkg::mbStatusT mbStatus
);

  mbBufferPkg::wordMaskT clrMask;
  mbBufferPkg::wordMaskT nextWrRq;
  mbBufferPkg::wordIdxT  lowestIdx;
  mbBufferPkg::wordIdxT  nextSel;
  logic                  selPending;

  //////////////////////
  // Request mask
  //////////////////////

  // Clear hits only the selected word
  assign clrMask = mbWrRqClr ? (mbBufferPkg::wordMaskT'(1) << mbStatus.mbSel) : '0;

  // Incoming words win over a clear of the same word
  assign nextWrRq = (mbStatus.mbWrRq & ~clrMask) | wordsComing;

  //////////////////////
  // Word select
  //////////////////////

  assign selPending = mbStatus.mbWrRq[mbStatus.mbSel];

  // Lowest pending word of the next mask, scan from the top down
  always_comb begin
    lowestIdx = mbStatus.mbSel;
    for (int i = mbBufferPkg::mbWords - 1; i >= 0; i--) begin
      if (nextWrRq[i]) begin
        lowestIdx = mbBufferPkg::wordIdxT'(i);
      end
    end
  end

  // Stay on a word until its request drops
  always_comb begin
    if (selPending) begin
      nextSel = mbStatus.mbSel;
    end else begin
      nextSel = lowestIdx;
    end
  end

  //////////////////////
  // Status register
  //////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mbStatus.mbWrRq    <= '0;
      mbStatus.mbSel     <= '0;
      mbStatus.mbReqHold <= 1'b0;
    end else begin
      mbStatus.mbWrRq    <= nextWrRq;
      mbStatus.mbSel     <= nextSel;
      // Taken from the next mask so it tracks mbWrRq in the same cycle
      mbStatus.mbReqHold <= |nextWrRq;
    end
  end

endmodule

/* design/memRequestGen.sv */
// Per-word memory request vector and memory read and write request strobes
`timescale 1ns/100ps

module memRequestGen (
  input  logic                  clk,
  input  logic                  rstN,
  input  mbCyclePkg::cycleReqT  cycReq,
  input  mbBufferPkg::wordMaskT mbWrRq,
  input  logic                  cacheToMbT4,
  output mbCyclePkg::memReqT    memReq
);

  logic                  oneWordRd;
  logic                  wrWdsInMb;
  logic                  rdNonValWds;
  logic                  oneWordWr;
  mbBufferPkg::wordMaskT adrTerm;
  mbBufferPkg::wordMaskT wrTerm;
  mbBufferPkg::wordMaskT nonValTerm;

  //////////////////////
  // Cycle decode
  //////////////////////

  always_comb begin
    oneWordRd   = 1'b0;
    wrWdsInMb   = 1'b0;
    rdNonValWds = 1'b0;
    oneWordWr   = 1'b0;
    case (cycReq.cycType)
      mbCyclePkg::cycOneWordRead: oneWordRd = 1'b1;
      mbCyclePkg::cycOneWordWrite: begin
        wrWdsInMb = 1'b1;
        oneWordWr = 1'b1;
      end
      mbCyclePkg::cycWriteback: wrWdsInMb = 1'b1;
      // Multi-word reads fetch what the line is missing
      mbCyclePkg::cycCoreRead,
      mbCyclePkg::cycPageRefill: rdNonValWds = 1'b1;
      default: ;
    endcase
  end

  //////////////////////
  // Word terms
  //////////////////////

  assign adrTerm    = oneWordRd ? (mbBufferPkg::wordMaskT'(1) << cycReq.wordAdr) : '0;
  assign wrTerm     = wrWdsInMb ? mbWrRq : '0;
  assign nonValTerm = rdNonValWds ? ~cycReq.cshWdVal : '0;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memReq <= '0;
    end else begin
      memReq.rqIn      <= adrTerm | wrTerm | nonValTerm;
      memReq.memRdRqIn <= oneWordRd | rdNonValWds;
      // Writeback T4 hands a buffer word to memory
      memReq.memWrRqIn <= cacheToMbT4 | oneWordWr;
    end
  end

endmodule

/* design/cacheToMbSequencer.sv */
// Writeback sequencer FSM for out-enable and phases T1 to T4 with done pulse
`timescale 1ns/100ps

module cacheToMbSequencer (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  writebackT1,
  input  logic                  phaseChangeComing,
  input  mbBufferPkg::wordMaskT mbWrRq,
  output logic                  cshWrOutEn,
  output logic                  cacheToMbT4,
  output logic                  cacheToMbDone
);

  mbCyclePkg::seqStateT state;
  mbCyclePkg::seqStateT nextState;
  logic                 wordsLeft;

  assign wordsLeft = |mbWrRq;

  //////////////////////
  // Next state
  //////////////////////

  always_comb begin
    nextState = state;
    case (state)
      mbCyclePkg::seqIdle: begin
        // Start pulses during a writeback are dropped
        if (writebackT1) begin
          nextState = mbCyclePkg::seqOutEn;
        end
      end
      mbCyclePkg::seqOutEn: nextState = mbCyclePkg::seqT1;
      mbCyclePkg::seqT1: begin
        if (wordsLeft) begin
          nextState = mbCyclePkg::seqT2;
        end else begin
          nextState = mbCyclePkg::seqIdle;
        end
      end
      mbCyclePkg::seqT2: begin
        // Hold until the memory phase turns over
        if (phaseChangeComing) begin
          nextState = mbCyclePkg::seqT3;
        end
      end
      mbCyclePkg::seqT3: nextState = mbCyclePkg::seqT4;
      mbCyclePkg::seqT4: nextState = mbCyclePkg::seqT1;
      default: nextState = mbCyclePkg::seqIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= mbCyclePkg::seqIdle;
    end else begin
      state <= nextState;
    end
  end

  //////////////////////
  // Pulses
  //////////////////////

  assign cshWrOutEn    = (state == mbCyclePkg::seqOutEn);
  assign cacheToMbT4   = (state == mbCyclePkg::seqT4);
  // T1 with an empty buffer ends the writeback
  assign cacheToMbDone = (state == mbCyclePkg::seqT1) && !wordsLeft;

endmodule

/* design/mbxTop.sv */
// MB control top level with word request tracker, memory request generator and writeback sequencer
`timescale 1ns/100ps

module mbxTop (
  input  logic                  clk,
  input  logic                  rstN,
  input  mbCyclePkg::cycleReqT  cycReq,
  input  mbBufferPkg::wordMaskT wordsComing,
  input  logic                  mbWrRqClr,
  input  logic                  writebackT1,
  input  logic                  phaseChangeComing,
  output mbBufferPkg::mbStatusT mbStatus,
  output mbCyclePkg::memReqT    memReq,
  output logic                  cshWrOutEn,
  output logic                  cacheToMbT4,
  output logic                  cacheToMbDone
);

  // Per-word write requests, select and hold flag
  wordRequestTracker tracker_i (
    .clk         (clk),
    .rstN        (rstN),
    .wordsComing (wordsComing),
    .mbWrRqClr   (mbWrRqClr),
    .mbStatus    (mbStatus)
  );

  // RQ_IN vector and memory strobes
  memRequestGen reqGen_i (
    .clk         (clk),
    .rstN        (rstN),
    .cycReq      (cycReq),
    .mbWrRq      (mbStatus.mbWrRq),
    .cacheToMbT4 (cacheToMbT4),
    .memReq      (memReq)
  );

  // Cache to MB writeback phases
  cacheToMbSequencer seq_i (
    .clk               (clk),
    .rstN              (rstN),
    .writebackT1       (writebackT1),
    .phaseChangeComing (phaseChangeComing),
    .mbWrRq            (mbStatus.mbWrRq),
    .cshWrOutEn        (cshWrOutEn),
    .cacheToMbT4       (cacheToMbT4),
    .cacheToMbDone     (cacheToMbDone)
  );

endmodule

/* testbench/mbxChecks_assert.sv */
// Concurrent assertions on writeback pulse timing, write strobe and request hold flag
`timescale 1ns/100ps

module mbxChecks (
  input logic                  clk,
  input logic                  rstN,
  input logic                  cshWrOutEn,
  input logic                  cacheToMbT4,
  input logic                  cacheToMbDone,
  input logic                  phaseChangeComing,
  input logic                  memWrRqIn,
  input mbBufferPkg::mbStatusT mbStatus
);

  int unsigned assertFails = 0;

  // Out-enable leads to done in T1 or to T4 four cycles later when T2 sees the phase change
  outEnToPhase: assert property (@(posedge clk) disable iff (!rstN)
    ($past(cshWrOutEn, 4) && $past(phaseChangeComing, 2))
    |-> (cacheToMbT4 || $past(cacheToMbDone, 3)))
    else begin
      assertFails++;
      $error("out-enable not followed by T4 or done");
    end

  t4ToWrite: assert property (@(posedge clk) disable iff (!rstN) cacheToMbT4 |=> memWrRqIn)
    else begin
      assertFails++;
      $error("T4 not followed by memory write request");
    end

  onePulse: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0({cshWrOutEn, cacheToMbT4, cacheToMbDone}))
    else begin
      assertFails++;
      $error("more than one sequencer pulse active");
    end

  holdMatchesMask: assert property (@(posedge clk) disable iff (!rstN)
    mbStatus.mbReqHold == (|mbStatus.mbWrRq))
    else begin
      assertFails++;
      $error("request hold differs from OR of write requests");
    end

endmodule

bind mbxTop mbxChecks checks_i (
  .clk               (clk),
  .rstN              (rstN),
  .cshWrOutEn        (cshWrOutEn),
  .cacheToMbT4       (cacheToMbT4),
  .cacheToMbDone     (cacheToMbDone),
  .phaseChangeComing (phaseChangeComing),
  .memWrRqIn         (memReq.memWrRqIn),
  .mbStatus          (mbStatus)
);

/* testbench/mbxModel.svh */
// Reference functions for the memory request vector, lowest pending word and request mask update
`ifndef MBX_MODEL_SVH
`define MBX_MODEL_SVH

// Mask after one edge, an incoming word survives a clear of the same word
function automatic mbBufferPkg::wordMaskT maskUpdate(mbBufferPkg::wordMaskT cur,
                                                     mbBufferPkg::wordMaskT coming,
                                                     logic clr, mbBufferPkg::wordIdxT sel);
  mbBufferPkg::wordMaskT res;
  res = cur;
  if (clr) begin
    res[sel] = 1'b0;
  end
  return res | coming;
endfunction

// Lowest set bit, or keep when the mask is empty
function automatic mbBufferPkg::wordIdxT lowestPending(mbBufferPkg::wordMaskT mask,
                                                      mbBufferPkg::wordIdxT keep);
  mbBufferPkg::wordIdxT idx;
  logic                 found;
  idx = keep;
  found = 1'b0;
  for (int i = 0; i < 4; i++) begin
    if (mask[i] && !found) begin
      idx = 2'(i);
      found = 1'b1;
    end
  end
  return idx;
endfunction

function automatic mbCyclePkg::memReqT memRequest(mbCyclePkg::cycleReqT req,
                                                  mbBufferPkg::wordMaskT wrRq, logic t4);
  mbCyclePkg::memReqT res;
  logic               rdOne;
  logic               wrAny;
  logic               rdLine;
  rdOne  = req.cycType == mbCyclePkg::cycOneWordRead;
  wrAny  = req.cycType == mbCyclePkg::cycOneWordWrite || req.cycType == mbCyclePkg::cycWriteback;
  rdLine = req.cycType == mbCyclePkg::cycCoreRead || req.cycType == mbCyclePkg::cycPageRefill;
  for (int i = 0; i < 4; i++) begin
    res.rqIn[i] = (rdOne && int'(req.wordAdr) == i) || (wrAny && wrRq[i])
                  || (rdLine && !req.cshWdVal[i]);
  end
  res.memRdRqIn = rdOne || rdLine;
  res.memWrRqIn = t4 || req.cycType == mbCyclePkg::cycOneWordWrite;
  return res;
endfunction

`endif

/* testbench/mbxTb.sv */
// Testbench top with clock, reset, LCG stimulus, reference compare, watchdog and summary
`timescale 1ns/100ps

module mbxTb;

  localparam int maskCycles = 200;
  localparam int reqCycles  = 200;
  localparam int selRounds  = 20;
  localparam int wbRounds   = 8;
  localparam int wbLimit    = 64;
  // All test phases plus slack for T2 waits
  localparam int runCycles  = 16 + maskCycles + reqCycles + selRounds * 12
                              + (wbRounds + 1) * (wbLimit + 16) + 200;

  logic                  clk = 1'b0;
  logic                  rstN;
  mbCyclePkg::cycleReqT  cycReq;
  mbBufferPkg::wordMaskT wordsComing;
  logic                  mbWrRqClr;
  logic                  writebackT1;
  logic                  phaseChangeComing;
  mbBufferPkg::mbStatusT mbStatus;
  mbCyclePkg::memReqT    memReq;
  logic                  cshWrOutEn;
  logic                  cacheToMbT4;
  logic                  cacheToMbDone;

  logic [31:0]           lcgState = 32'hc787;
  int                    checks = 0;
  int                    errors = 0;
  int                    seqErrors = 0;
  int                    testErrStart = 0;
  int                    t4Count;
  int                    doneCount;
  int                    outEnCount;
  logic                  expValid = 1'b0;
  logic                  wasReset = 1'b0;
  mbBufferPkg::mbStatusT expStatus;
  mbBufferPkg::mbStatusT curStatus;
  mbCyclePkg::memReqT    expMem;

  `include "mbxModel.svh"

  mbxTop dut_i (
    .clk               (clk),
    .rstN              (rstN),
    .cycReq            (cycReq),
    .wordsComing       (wordsComing),
    .mbWrRqClr         (mbWrRqClr),
    .writebackT1       (writebackT1),
    .phaseChangeComing (phaseChangeComing),
    .mbStatus          (mbStatus),
    .memReq            (memReq),
    .cshWrOutEn        (cshWrOutEn),
    .cacheToMbT4       (cacheToMbT4),
    .cacheToMbDone     (cacheToMbDone)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    // Upper half only since the low LCG bits repeat quickly
    return {16'h0, lcgState[31:16]};
  endfunction

  ////////////////////
  // Compare process
  ////////////////////

  // Sampled at the falling edge where outputs and next-edge inputs are stable
  always @(negedge clk) begin
    if (expValid) begin
      checks++;
      assert (mbStatus.mbWrRq == expStatus.mbWrRq) else begin
        $display("mismatch mbStatus.mbWrRq: got %h expected %h", mbStatus.mbWrRq,
                 expStatus.mbWrRq);
        errors++;
      end
      assert (mbStatus.mbSel == expStatus.mbSel) else begin
        $display("mismatch mbStatus.mbSel: got %h expected %h", mbStatus.mbSel,
                 expStatus.mbSel);
        errors++;
      end
      assert (mbStatus.mbReqHold == expStatus.mbReqHold) else begin
        $display("mismatch mbStatus.mbReqHold: got %h expected %h", mbStatus.mbReqHold,
                 expStatus.mbReqHold);
        errors++;
      end
      assert (memReq.rqIn == expMem.rqIn) else begin
        $display("mismatch memReq.rqIn: got %h expected %h", memReq.rqIn, expMem.rqIn);
        errors++;
      end
      assert (memReq.memRdRqIn == expMem.memRdRqIn) else begin
        $display("mismatch memReq.memRdRqIn: got %h expected %h", memReq.memRdRqIn,
                 expMem.memRdRqIn);
        errors++;
      end
      assert (memReq.memWrRqIn == expMem.memWrRqIn) else begin
        $display("mismatch memReq.memWrRqIn: got %h expected %h", memReq.memWrRqIn,
                 expMem.memWrRqIn);
        errors++;
      end
      assert (!wasReset || {cshWrOutEn, cacheToMbT4, cacheToMbDone} == 3'b000) else begin
        $display("a sequencer pulse was active during reset or right after it");
        errors++;
      end
    end
    wasReset = !rstN;
    if (!rstN) begin
      expStatus = '0;
      expMem = '0;
    end else begin
      curStatus = expStatus;
      expStatus.mbWrRq = maskUpdate(curStatus.mbWrRq, wordsComing, mbWrRqClr,
                                    curStatus.mbSel);
      // Select stays while its own word is pending
      expStatus.mbSel = curStatus.mbWrRq[curStatus.mbSel] ? curStatus.mbSel
                        : lowestPending(expStatus.mbWrRq, curStatus.mbSel);
      expStatus.mbReqHold = |expStatus.mbWrRq;
      expMem = memRequest(cycReq, curStatus.mbWrRq, cacheToMbT4);
    end
    expValid = 1'b1;
  end

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic finishTest(string name);
    $display("test %s finished with %0d errors", name, errors + seqErrors - testErrStart);
    testErrStart = errors + seqErrors;
  endtask

  task automatic drainBuffer();
    int n;
    n = 0;
    while (mbStatus.mbReqHold && n < 8) begin
      mbWrRqClr = 1'b1;
      step();
      n++;
    end
    mbWrRqClr = 1'b0;
    assert (!mbStatus.mbReqHold) else begin
      $display("buffer still holds write requests after clearing");
      seqErrors++;
    end
  endtask

  // Loads a random nonzero set of words into an empty buffer
  task automatic preload(output int words);
    mbBufferPkg::wordMaskT w;
    w = 4'(nextRand());
    if (w == '0) begin
      w = 4'b0100;
    end
    words = $countones(w);
    wordsComing = w;
    step();
    wordsComing = '0;
  endtask

  // Clears the selected word on every T4 as the MB takes it
  task automatic watchPulses();
    mbWrRqClr = cacheToMbT4;
    if (cacheToMbT4) t4Count++;
    if (cacheToMbDone) doneCount++;
    if (cshWrOutEn) outEnCount++;
    step();
  endtask

  task automatic runWriteback(int words);
    int n;
    n = 0;
    t4Count = 0;
    doneCount = 0;
    outEnCount = 0;
    phaseChangeComing = 1'b1;
    writebackT1 = 1'b1;
    step();
    writebackT1 = 1'b0;
    while (doneCount == 0 && n < wbLimit) begin
      watchPulses();
      n++;
    end
    // A few more cycles to catch stray pulses
    repeat (4) watchPulses();
    mbWrRqClr = 1'b0;
    phaseChangeComing = 1'b0;
    assert (doneCount != 0) else begin
      $display("writeback did not finish within %0d cycles", wbLimit);
      seqErrors++;
    end
    assert (t4Count == words) else begin
      $display("mismatch cacheToMbT4 count: got %h expected %h", t4Count, words);
      seqErrors++;
    end
    assert (doneCount == 1) else begin
      $display("mismatch cacheToMbDone count: got %h expected %h", doneCount, 1);
      seqErrors++;
    end
    assert (outEnCount == 1) else begin
      $display("mismatch cshWrOutEn count: got %h expected %h", outEnCount, 1);
      seqErrors++;
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] q;
    int          words;
    int          totalErr;
    rstN = 1'b0;
    cycReq = '0;
    wordsComing = '0;
    mbWrRqClr = 1'b0;
    writebackT1 = 1'b0;
    phaseChangeComing = 1'b0;
    repeat (10) step();
    rstN = 1'b1;
    step();
    step();
    finishTest("reset");

    for (int i = 0; i < maskCycles; i++) begin
      r = nextRand();
      wordsComing = r[3:0] & r[7:4];
      mbWrRqClr = r[8];
      step();
    end
    wordsComing = '0;
    mbWrRqClr = 1'b0;
    drainBuffer();
    finishTest("request mask");

    for (int i = 0; i < selRounds; i++) begin
      preload(words);
      drainBuffer();
    end
    finishTest("word select");

    for (int i = 0; i < reqCycles; i++) begin
      r = nextRand();
      q = nextRand();
      cycReq.cycType = mbCyclePkg::cycleTypeT'(3'(r % 32'd6));
      cycReq.wordAdr = r[5:4];
      cycReq.cshWdVal = r[11:8];
      wordsComing = q[3:0] & q[7:4];
      mbWrRqClr = q[8];
      step();
    end
    cycReq = '0;
    wordsComing = '0;
    mbWrRqClr = 1'b0;
    drainBuffer();
    finishTest("request generation");

    for (int i = 0; i < wbRounds; i++) begin
      preload(words);
      runWriteback(words);
    end
    finishTest("writeback loop");

    runWriteback(0);
    finishTest("empty writeback");

    step();
    totalErr = errors + seqErrors + int'(dut_i.checks_i.assertFails);
    $display("checks %0d, compare errors %0d, sequence errors %0d, assertion failures %0d",
             checks, errors, seqErrors, dut_i.checks_i.assertFails);
    if (totalErr == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(runCycles * 4);
    $display("timeout, run did not end within %0d cycles", runCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* mbx.f */
+incdir+testbench
design/mbBufferPkg.sv
design/mbCyclePkg.sv
design/wordRequestTracker.sv
design/memRequestGen.sv
design/cacheToMbSequencer.sv
design/mbxTop.sv
testbench/mbxChecks_assert.sv
testbench/mbxTb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = mbxTb
FLIST = mbx.f
PASS  = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS)'

clean:
	rm -rf obj_dir
